//--- filelist.f
hdl/mipsPkg.sv
hdl/decodeIfs.sv
hdl/instrDecoder.sv
hdl/branchResolver.sv
hdl/decodeCombine.sv
hdl/decodeStage.sv
test/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# build the decode stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module decodeStageTb \
	-f filelist.f -o decodeSim || { echo "build failed"; exit 1; }
out=$(./obj_dir/decodeSim)
echo "$out"
echo "$out" | grep -qx "TESTBENCH PASSED" && echo "simulation ok" || { echo "simulation not ok"; exit 1; }

//--- test/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb import mipsPkg::*; ();

	// how a row resolves its branch outcome or its jump target
	typedef enum logic [2:0] {
		R_NONE, R_EQ, R_NE, R_GEZ, R_LTZ, R_GTZ, R_LEZ, R_JREG
	} rule_t;

	logic       clk = 1'b0;
	logic       arstN;
	logic       inValid;
	logic       fetchExc;
	word_t      instr, pcPlus4, srcA, srcB;
	logic       outValid;
	instrOp_t   op;
	logic       regWrite, memRead, memWrite, branch, jump;
	logic       aluSrcImm, regDst, link, zeroExt;
	aluFunc_t   aluFunc;
	word_t      extImm, pcPlus4Out, pcBranch, jumpTarget;
	regIdx_t    rs, rt, rd;
	logic [4:0] shamt;
	logic       branchTaken;
	logic       exc;
	word_t      seed;

	// stimulus table, one entry per row in each queue
	word_t      rowWord[$];
	instrOp_t   rowOp[$];
	logic [8:0] rowCtl[$];
	aluFunc_t   rowAlu[$];
	rule_t      rowRule[$];

	// strobes that are in flight, oldest first
	int         sentRow[$];
	word_t      sentA[$], sentB[$], sentPc[$];
	logic       sentExc[$];

	decodeStage uut (.*);

	always #5 clk = ~clk;

	function automatic word_t nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic word_t encodeR(input logic [5:0] fn);
		return {OP_RTYPE, 5'd3, 5'd4, 5'd5, 5'd7, fn};
	endfunction

	// bit 15 of the immediate is set so sign and zero extension differ
	function automatic word_t encodeI(input logic [5:0] opc, input logic [4:0] rtCode);
		return {opc, 5'd17, rtCode, 16'hb6d4};
	endfunction

	function automatic word_t encodeJ(input logic [5:0] opc);
		return {opc, 26'h2a5c3e1};
	endfunction

	task automatic addRow(input word_t w, input instrOp_t o, input logic [8:0] c,
		input aluFunc_t f, input rule_t r);
		rowWord.push_back(w);
		rowOp.push_back(o);
		rowCtl.push_back(c);
		rowAlu.push_back(f);
		rowRule.push_back(r);
	endtask

	task automatic compare(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// mode 0 equal operands, 1 negative srcA, 2 zero srcA, 3 positive srcA
	task automatic sendOne(input int idx, input int mode);
		word_t a, b, r;
		a = nextRand();
		b = nextRand();
		r = nextRand();
		case (mode)
			0: b = a;
			1: a[31] = 1'b1;
			2: a = '0;
			default: begin
				a[31] = 1'b0;
				a[0] = 1'b1;
			end
		endcase
		@(posedge clk);
		inValid  <= 1'b1;
		instr    <= rowWord[idx];
		srcA     <= a;
		srcB     <= b;
		pcPlus4  <= {r[31:2], 2'b00};
		fetchExc <= r[0];
		sentRow.push_back(idx);
		sentA.push_back(a);
		sentB.push_back(b);
		sentPc.push_back({r[31:2], 2'b00});
		sentExc.push_back(r[0]);
	endtask

	task automatic waitOut();
		int n;
		n = 0;
		@(negedge clk);
		while (!outValid) begin
			n++;
			if (n > 20) begin
				$display("outValid never rose after a strobe");
				$display("TESTBENCH FAILED");
				$fatal(1, "timeout");
			end
			@(negedge clk);
		end
	endtask

	task automatic checkOut();
		int idx;
		word_t w, a, b, pc, expImm, expBranch, expJump;
		logic expTaken;
		idx = sentRow.pop_front();
		a = sentA.pop_front();
		b = sentB.pop_front();
		pc = sentPc.pop_front();
		w = rowWord[idx];
		expImm = rowCtl[idx][0] ? {16'b0, w[15:0]} : {{16{w[15]}}, w[15:0]};
		expBranch = pc + {{14{w[15]}}, w[15:0], 2'b00};
		expJump = (rowRule[idx] == R_JREG) ? a : {pc[31:28], w[25:0], 2'b00};
		case (rowRule[idx])
			R_EQ:    expTaken = (a == b);
			R_NE:    expTaken = (a != b);
			R_GEZ:   expTaken = ($signed(a) >= 0);
			R_LTZ:   expTaken = ($signed(a) < 0);
			R_GTZ:   expTaken = ($signed(a) > 0);
			R_LEZ:   expTaken = ($signed(a) <= 0);
			default: expTaken = 1'b0;
		endcase
		compare("outValid", 32'(outValid), 32'd1);
		compare("op", 32'(op), 32'(rowOp[idx]));
		compare("ctl", 32'({regWrite, memRead, memWrite, branch, jump,
			aluSrcImm, regDst, link, zeroExt}), 32'(rowCtl[idx]));
		compare("aluFunc", 32'(aluFunc), 32'(rowAlu[idx]));
		compare("extImm", extImm, expImm);
		compare("rs", 32'(rs), 32'(w[25:21]));
		compare("rt", 32'(rt), 32'(w[20:16]));
		compare("rd", 32'(rd), 32'(w[15:11]));
		compare("shamt", 32'(shamt), 32'(w[10:6]));
		compare("pcPlus4Out", pcPlus4Out, pc);
		compare("pcBranch", pcBranch, expBranch);
		compare("jumpTarget", jumpTarget, expJump);
		compare("branchTaken", 32'(branchTaken), 32'(expTaken));
		compare("exc", 32'(exc), 32'(sentExc.pop_front() | (rowOp[idx] == OP_RESERVED)));
	endtask

	initial begin
		seed = 32'd44;
		arstN    <= 1'b0;
		inValid  <= 1'b0;
		fetchExc <= 1'b0;
		instr    <= '0;
		pcPlus4  <= '0;
		srcA     <= '0;
		srcB     <= '0;

		// ****************************************
		// control bits: regWrite memRead memWrite branch jump aluSrcImm regDst link zeroExt
		// ****************************************
		addRow(encodeR(FN_SLL), I_SLL, 9'b100000100, ALU_SLL, R_NONE);
		addRow(encodeR(FN_SRL), I_SRL, 9'b100000100, ALU_SRL, R_NONE);
		addRow(encodeR(FN_SRA), I_SRA, 9'b100000100, ALU_SRA, R_NONE);
		addRow(encodeR(FN_SLLV), I_SLLV, 9'b100000100, ALU_SLL, R_NONE);
		addRow(encodeR(FN_SRLV), I_SRLV, 9'b100000100, ALU_SRL, R_NONE);
		addRow(encodeR(FN_SRAV), I_SRAV, 9'b100000100, ALU_SRA, R_NONE);
		addRow(encodeR(FN_ADD), I_ADD, 9'b100000100, ALU_ADD, R_NONE);
		addRow(encodeR(FN_ADDU), I_ADDU, 9'b100000100, ALU_ADD, R_NONE);
		addRow(encodeR(FN_SUB), I_SUB, 9'b100000100, ALU_SUB, R_NONE);
		addRow(encodeR(FN_SUBU), I_SUBU, 9'b100000100, ALU_SUB, R_NONE);
		addRow(encodeR(FN_AND), I_AND, 9'b100000100, ALU_AND, R_NONE);
		addRow(encodeR(FN_OR), I_OR, 9'b100000100, ALU_OR, R_NONE);
		addRow(encodeR(FN_XOR), I_XOR, 9'b100000100, ALU_XOR, R_NONE);
		addRow(encodeR(FN_NOR), I_NOR, 9'b100000100, ALU_NOR, R_NONE);
		addRow(encodeR(FN_SLT), I_SLT, 9'b100000100, ALU_SLT, R_NONE);
		addRow(encodeR(FN_SLTU), I_SLTU, 9'b100000100, ALU_SLTU, R_NONE);
		addRow(encodeR(FN_JR), I_JR, 9'b000010100, ALU_ADD, R_JREG);
		addRow(encodeR(FN_JALR), I_JALR, 9'b100010110, ALU_ADD, R_JREG);
		addRow(encodeI(OP_REGIMM, RT_BLTZ), I_BLTZ, 9'b000100000, ALU_ADD, R_LTZ);
		addRow(encodeI(OP_REGIMM, RT_BGEZ), I_BGEZ, 9'b000100000, ALU_ADD, R_GEZ);
		addRow(encodeI(OP_REGIMM, RT_BLTZAL), I_BLTZAL, 9'b100100010, ALU_ADD, R_LTZ);
		addRow(encodeI(OP_REGIMM, RT_BGEZAL), I_BGEZAL, 9'b100100010, ALU_ADD, R_GEZ);
		addRow(encodeJ(OP_J), I_J, 9'b000010000, ALU_ADD, R_NONE);
		addRow(encodeJ(OP_JAL), I_JAL, 9'b100010010, ALU_ADD, R_NONE);
		addRow(encodeI(OP_BEQ, 5'd9), I_BEQ, 9'b000100000, ALU_SUB, R_EQ);
		addRow(encodeI(OP_BNE, 5'd9), I_BNE, 9'b000100000, ALU_SUB, R_NE);
		addRow(encodeI(OP_BLEZ, 5'd9), I_BLEZ, 9'b000100000, ALU_ADD, R_LEZ);
		addRow(encodeI(OP_BGTZ, 5'd9), I_BGTZ, 9'b000100000, ALU_ADD, R_GTZ);
		addRow(encodeI(OP_ADDI, 5'd9), I_ADDI, 9'b100001000, ALU_ADD, R_NONE);
		addRow(encodeI(OP_ADDIU, 5'd9), I_ADDIU, 9'b100001000, ALU_ADD, R_NONE);
		addRow(encodeI(OP_SLTI, 5'd9), I_SLTI, 9'b100001000, ALU_SLT, R_NONE);
		addRow(encodeI(OP_SLTIU, 5'd9), I_SLTIU, 9'b100001000, ALU_SLTU, R_NONE);
		addRow(encodeI(OP_ANDI, 5'd9), I_ANDI, 9'b100001001, ALU_AND, R_NONE);
		addRow(encodeI(OP_ORI, 5'd9), I_ORI, 9'b100001001, ALU_OR, R_NONE);
		addRow(encodeI(OP_XORI, 5'd9), I_XORI, 9'b100001001, ALU_XOR, R_NONE);
		addRow(encodeI(OP_LUI, 5'd9), I_LUI, 9'b100001000, ALU_LUI, R_NONE);
		addRow(encodeI(OP_LB, 5'd9), I_LB, 9'b110001000, ALU_ADD, R_NONE);
		addRow(encodeI(OP_LH, 5'd9), I_LH, 9'b110001000, ALU_ADD, R_NONE);
		addRow(encodeI(OP_LW, 5'd9), I_LW, 9'b110001000, ALU_ADD, R_NONE);
		addRow(encodeI(OP_LBU, 5'd9), I_LBU, 9'b110001000, ALU_ADD, R_NONE);
		addRow(encodeI(OP_LHU, 5'd9), I_LHU, 9'b110001000, ALU_ADD, R_NONE);
		addRow(encodeI(OP_SB, 5'd9), I_SB, 9'b001001000, ALU_ADD, R_NONE);
		addRow(encodeI(OP_SH, 5'd9), I_SH, 9'b001001000, ALU_ADD, R_NONE);
		addRow(encodeI(OP_SW, 5'd9), I_SW, 9'b001001000, ALU_ADD, R_NONE);
		// unassigned opcode, funct and rt-code
		addRow(encodeI(6'h10, 5'd9), OP_RESERVED, 9'b000000000, ALU_ADD, R_NONE);
		addRow(encodeI(6'h3f, 5'd9), OP_RESERVED, 9'b000000000, ALU_ADD, R_NONE);
		addRow(encodeR(6'h01), OP_RESERVED, 9'b000000000, ALU_ADD, R_NONE);
		addRow(encodeI(OP_REGIMM, 5'h02), OP_RESERVED, 9'b000000000, ALU_ADD, R_NONE);

		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		compare("outValid", 32'(outValid), 32'd0);
		compare("op", 32'(op), 32'(OP_RESERVED));
		compare("ctl", 32'({regWrite, memRead, memWrite, branch, jump,
			aluSrcImm, regDst, link, zeroExt}), 32'd0);
		compare("aluFunc", 32'(aluFunc), 32'(ALU_ADD));
		compare("extImm", extImm, 32'd0);
		compare("rs", 32'(rs), 32'd0);
		compare("rt", 32'(rt), 32'd0);
		compare("rd", 32'(rd), 32'd0);
		compare("shamt", 32'(shamt), 32'd0);
		compare("pcPlus4Out", pcPlus4Out, 32'd0);
		compare("pcBranch", pcBranch, 32'd0);
		compare("jumpTarget", jumpTarget, 32'd0);
		compare("branchTaken", 32'(branchTaken), 32'd0);
		compare("exc", 32'(exc), 32'd0);

		// ****************************************
		// single strobes, every row under every operand case
		// ****************************************
		foreach (rowWord[i]) begin
			for (int m = 0; m < 4; m++) begin
				sendOne(i, m);
				@(posedge clk);
				inValid <= 1'b0;
				// a different word while idle must not reach the bundle
				instr   <= ~rowWord[i];
				waitOut();
				checkOut();
				@(negedge clk);
				compare("outValid", 32'(outValid), 32'd0);
				compare("op", 32'(op), 32'(rowOp[i]));
			end
		end

		// back-to-back strobes must give one result per cycle
		for (int i = 0; i < 12; i++) begin
			sendOne((i * 7) % rowWord.size(), i % 4);
			@(negedge clk);
			if (i > 0)
				checkOut();
		end
		@(posedge clk);
		inValid <= 1'b0;
		waitOut();
		checkOut();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import mipsPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  logic       inValid,
	input  word_t      instr,
	input  word_t      pcPlus4,
	input  logic       fetchExc,
	input  word_t      srcA,
	input  word_t      srcB,
	output logic       outValid,
	output instrOp_t   op,
	output logic       regWrite,
	output logic       memRead,
	output logic       memWrite,
	output logic       branch,
	output logic       jump,
	output logic       aluSrcImm,
	output logic       regDst,
	output logic       link,
	output logic       zeroExt,
	output aluFunc_t   aluFunc,
	output word_t      extImm,
	output regIdx_t    rs,
	output regIdx_t    rt,
	output regIdx_t    rd,
	output logic [4:0] shamt,
	output word_t      pcPlus4Out,
	output word_t      pcBranch,
	output word_t      jumpTarget,
	output logic       branchTaken,
	output logic       exc
);

	ctl_t ctlOut;

	fetchIf   fetchBus ();
	decodedIf decBus ();
	branchIf  brBus ();

	assign fetchBus.valid    = inValid;
	assign fetchBus.instr    = instrWord_t'(instr);
	assign fetchBus.pcPlus4  = pcPlus4;
	assign fetchBus.fetchExc = fetchExc;
	assign fetchBus.srcA     = srcA;
	assign fetchBus.srcB     = srcB;

	// decoder and resolver both work on the same fetched word
	instrDecoder uDecoder (
		.fetch (fetchBus),
		.dec   (decBus)
	);

	branchResolver uResolver (
		.fetch (fetchBus),
		.br    (brBus)
	);

	decodeCombine uCombine (
		.clk         (clk),
		.arstN       (arstN),
		.fetch       (fetchBus),
		.dec         (decBus),
		.br          (brBus),
		.outValid    (outValid),
		.op          (op),
		.ctl         (ctlOut),
		.aluFunc     (aluFunc),
		.extImm      (extImm),
		.rs          (rs),
		.rt          (rt),
		.rd          (rd),
		.shamt       (shamt),
		.pcPlus4Out  (pcPlus4Out),
		.pcBranch    (pcBranch),
		.jumpTarget  (jumpTarget),
		.branchTaken (branchTaken),
		.exc         (exc)
	);

	assign regWrite  = ctlOut.regWrite;
	assign memRead   = ctlOut.memRead;
	assign memWrite  = ctlOut.memWrite;
	assign branch    = ctlOut.branch;
	assign jump      = ctlOut.jump;
	assign aluSrcImm = ctlOut.aluSrcImm;
	assign regDst    = ctlOut.regDst;
	assign link      = ctlOut.link;
	assign zeroExt   = ctlOut.zeroExt;

endmodule

//--- hdl/decodeCombine.sv
`timescale 1ns/1ps

module decodeCombine import mipsPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	fetchIf.sink       fetch,
	decodedIf.sink     dec,
	branchIf.sink      br,
	output logic       outValid,
	output instrOp_t   op,
	output ctl_t       ctl,
	output aluFunc_t   aluFunc,
	output word_t      extImm,
	output regIdx_t    rs,
	output regIdx_t    rt,
	output regIdx_t    rd,
	output logic [4:0] shamt,
	output word_t      pcPlus4Out,
	output word_t      pcBranch,
	output word_t      jumpTarget,
	output logic       branchTaken,
	output logic       exc
);

	logic  taken;
	word_t target;

	// the REGIMM link branches test like their plain forms
	always_comb begin
		case (dec.op)
			I_BEQ:             taken = br.eq;
			I_BNE:             taken = !br.eq;
			I_BGEZ, I_BGEZAL:  taken = !br.srcANeg;
			I_BLTZ, I_BLTZAL:  taken = br.srcANeg;
			I_BGTZ:            taken = !br.srcANeg && !br.srcAZero;
			I_BLEZ:            taken = br.srcANeg || br.srcAZero;
			default:           taken = 1'b0;
		endcase
	end

	// register jumps go to the rs operand
	assign target = (dec.op == I_JR || dec.op == I_JALR) ? fetch.srcA : br.pcJump;

	// ****************************************
	// output register
	// ****************************************
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid    <= 1'b0;
			op          <= OP_RESERVED;
			ctl         <= '0;
			aluFunc     <= ALU_ADD;
			extImm      <= '0;
			rs          <= '0;
			rt          <= '0;
			rd          <= '0;
			shamt       <= '0;
			pcPlus4Out  <= '0;
			pcBranch    <= '0;
			jumpTarget  <= '0;
			branchTaken <= 1'b0;
			exc         <= 1'b0;
		end else begin
			outValid <= fetch.valid;
			// bundle holds its last value between strobes
			if (fetch.valid) begin
				op          <= dec.op;
				ctl         <= dec.ctl;
				aluFunc     <= dec.aluFunc;
				extImm      <= dec.extImm;
				rs          <= dec.rs;
				rt          <= dec.rt;
				rd          <= dec.rd;
				shamt       <= dec.shamt;
				pcPlus4Out  <= fetch.pcPlus4;
				pcBranch    <= br.pcBranch;
				jumpTarget  <= target;
				branchTaken <= taken;
				exc         <= fetch.fetchExc | dec.reserved;
			end
		end
	end

endmodule

//--- hdl/branchResolver.sv
`timescale 1ns/1ps

module branchResolver import mipsPkg::*; (
	fetchIf.sink     fetch,
	branchIf.source  br
);

	word_t       branchOffset;
	logic [15:0] imm;
	logic [25:0] target;

	assign imm    = fetch.instr.i.imm;
	assign target = fetch.instr.j.target;

	// ****************************************
	// targets
	// ****************************************

	// word offset, sign-extended and scaled to bytes
	assign branchOffset = {{14{imm[15]}}, imm, 2'b00};

	// branches are relative to the delay slot, so the base is PC+4
	assign br.pcBranch = fetch.pcPlus4 + branchOffset;

	// jumps stay in the 256 MB region of the delay slot
	assign br.pcJump = {fetch.pcPlus4[31:28], target, 2'b00};

	// ****************************************
	// operand compares
	// ****************************************
	assign br.eq       = (fetch.srcA == fetch.srcB);
	assign br.srcANeg  = fetch.srcA[31];
	assign br.srcAZero = (fetch.srcA == '0);

endmodule

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import mipsPkg::*; (
	fetchIf.sink      fetch,
	decodedIf.source  dec
);

	instrOp_t    opDec;
	aluFunc_t    aluDec;
	ctl_t        ctlDec;
	logic [15:0] imm;
	logic        reserved;
	logic        isRtype;
	logic        isAluR;
	logic        isAluI;
	logic        isLoad;
	logic        isStore;
	logic        isBranch;
	logic        isJump;
	logic        isLink;

	assign imm = fetch.instr.i.imm;

	// ****************************************
	// opcode, funct and rt-code to operation
	// ****************************************
	always_comb begin
		opDec = OP_RESERVED;
		case (fetch.instr.r.op)
			OP_RTYPE: begin
				case (fetch.instr.r.funct)
					FN_SLL:  opDec = I_SLL;
					FN_SRL:  opDec = I_SRL;
					FN_SRA:  opDec = I_SRA;
					FN_SLLV: opDec = I_SLLV;
					FN_SRLV: opDec = I_SRLV;
					FN_SRAV: opDec = I_SRAV;
					FN_JR:   opDec = I_JR;
					FN_JALR: opDec = I_JALR;
					FN_ADD:  opDec = I_ADD;
					FN_ADDU: opDec = I_ADDU;
					FN_SUB:  opDec = I_SUB;
					FN_SUBU: opDec = I_SUBU;
					FN_AND:  opDec = I_AND;
					FN_OR:   opDec = I_OR;
					FN_XOR:  opDec = I_XOR;
					FN_NOR:  opDec = I_NOR;
					FN_SLT:  opDec = I_SLT;
					FN_SLTU: opDec = I_SLTU;
					default: opDec = OP_RESERVED;
				endcase
			end
			OP_REGIMM: begin
				case (fetch.instr.i.rt)
					RT_BLTZ:   opDec = I_BLTZ;
					RT_BGEZ:   opDec = I_BGEZ;
					RT_BLTZAL: opDec = I_BLTZAL;
					RT_BGEZAL: opDec = I_BGEZAL;
					default:   opDec = OP_RESERVED;
				endcase
			end
			OP_J:     opDec = I_J;
			OP_JAL:   opDec = I_JAL;
			OP_BEQ:   opDec = I_BEQ;
			OP_BNE:   opDec = I_BNE;
			OP_BLEZ:  opDec = I_BLEZ;
			OP_BGTZ:  opDec = I_BGTZ;
			OP_ADDI:  opDec = I_ADDI;
			OP_ADDIU: opDec = I_ADDIU;
			OP_SLTI:  opDec = I_SLTI;
			OP_SLTIU: opDec = I_SLTIU;
			OP_ANDI:  opDec = I_ANDI;
			OP_ORI:   opDec = I_ORI;
			OP_XORI:  opDec = I_XORI;
			OP_LUI:   opDec = I_LUI;
			OP_LB:    opDec = I_LB;
			OP_LH:    opDec = I_LH;
			OP_LW:    opDec = I_LW;
			OP_LBU:   opDec = I_LBU;
			OP_LHU:   opDec = I_LHU;
			OP_SB:    opDec = I_SB;
			OP_SH:    opDec = I_SH;
			OP_SW:    opDec = I_SW;
			default:  opDec = OP_RESERVED;
		endcase
	end

	assign reserved = (opDec == OP_RESERVED);
	assign isRtype  = (fetch.instr.r.op == OP_RTYPE) && !reserved;

	// operation classes, none of them match OP_RESERVED so its controls stay zero
	assign isAluR = opDec inside {I_SLL, I_SRL, I_SRA, I_SLLV, I_SRLV, I_SRAV,
		I_ADD, I_ADDU, I_SUB, I_SUBU, I_AND, I_OR, I_XOR, I_NOR, I_SLT, I_SLTU};
	assign isAluI = opDec inside {I_ADDI, I_ADDIU, I_SLTI, I_SLTIU,
		I_ANDI, I_ORI, I_XORI, I_LUI};
	assign isLoad   = opDec inside {I_LB, I_LH, I_LW, I_LBU, I_LHU};
	assign isStore  = opDec inside {I_SB, I_SH, I_SW};
	assign isBranch = opDec inside {I_BEQ, I_BNE, I_BLEZ, I_BGTZ,
		I_BLTZ, I_BGEZ, I_BLTZAL, I_BGEZAL};
	assign isJump = opDec inside {I_J, I_JAL, I_JR, I_JALR};
	assign isLink = opDec inside {I_JAL, I_JALR, I_BLTZAL, I_BGEZAL};

	always_comb begin
		ctlDec.regWrite  = isAluR | isAluI | isLoad | isLink;
		ctlDec.memRead   = isLoad;
		ctlDec.memWrite  = isStore;
		ctlDec.branch    = isBranch;
		ctlDec.jump      = isJump;
		ctlDec.aluSrcImm = isAluI | isLoad | isStore;
		ctlDec.regDst    = isRtype;
		ctlDec.link      = isLink;
		ctlDec.zeroExt   = opDec inside {I_ANDI, I_ORI, I_XORI};
	end

	// address arithmetic for memory ops and jumps falls into the ALU_ADD default
	always_comb begin
		case (opDec)
			I_SUB, I_SUBU, I_BEQ, I_BNE: aluDec = ALU_SUB;
			I_AND, I_ANDI:               aluDec = ALU_AND;
			I_OR, I_ORI:                 aluDec = ALU_OR;
			I_XOR, I_XORI:               aluDec = ALU_XOR;
			I_NOR:                       aluDec = ALU_NOR;
			I_SLT, I_SLTI:               aluDec = ALU_SLT;
			I_SLTU, I_SLTIU:             aluDec = ALU_SLTU;
			I_SLL, I_SLLV:               aluDec = ALU_SLL;
			I_SRL, I_SRLV:               aluDec = ALU_SRL;
			I_SRA, I_SRAV:               aluDec = ALU_SRA;
			I_LUI:                       aluDec = ALU_LUI;
			default:                     aluDec = ALU_ADD;
		endcase
	end

	assign dec.op       = opDec;
	assign dec.ctl      = ctlDec;
	assign dec.aluFunc  = aluDec;
	assign dec.extImm   = ctlDec.zeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};
	assign dec.rs       = fetch.instr.r.rs;
	assign dec.rt       = fetch.instr.r.rt;
	assign dec.rd       = fetch.instr.r.rd;
	assign dec.shamt    = fetch.instr.r.shamt;
	assign dec.reserved = reserved;

endmodule

//--- hdl/decodeIfs.sv
`timescale 1ns/1ps

// fetched instruction with its operands, valid for a single cycle
interface fetchIf import mipsPkg::*; ();
	logic       valid;
	instrWord_t instr;
	word_t      pcPlus4;
	logic       fetchExc;
	word_t      srcA;
	word_t      srcB;

	modport source (output valid, instr, pcPlus4, fetchExc, srcA, srcB);
	modport sink (input valid, instr, pcPlus4, fetchExc, srcA, srcB);
endinterface

interface decodedIf import mipsPkg::*; ();
	instrOp_t   op;
	ctl_t       ctl;
	aluFunc_t   aluFunc;
	word_t      extImm;
	regIdx_t    rs;
	regIdx_t    rt;
	regIdx_t    rd;
	logic [4:0] shamt;
	logic       reserved;

	modport source (output op, ctl, aluFunc, extImm, rs, rt, rd, shamt, reserved);
	modport sink (input op, ctl, aluFunc, extImm, rs, rt, rd, shamt, reserved);
endinterface

// targets and operand compares, resolved in the decode cycle
interface branchIf import mipsPkg::*; ();
	word_t pcBranch;
	word_t pcJump;
	logic  eq;
	logic  srcANeg;
	logic  srcAZero;

	modport source (output pcBranch, pcJump, eq, srcANeg, srcAZero);
	modport sink (input pcBranch, pcJump, eq, srcANeg, srcAZero);
endinterface

//--- hdl/mipsPkg.sv
package mipsPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regIdx_t;

	// ****************************************
	// primary opcodes, instr[31:26]
	// ****************************************
	localparam logic [5:0] OP_RTYPE  = 6'h00;
	localparam logic [5:0] OP_REGIMM = 6'h01;
	localparam logic [5:0] OP_J      = 6'h02;
	localparam logic [5:0] OP_JAL    = 6'h03;
	localparam logic [5:0] OP_BEQ    = 6'h04;
	localparam logic [5:0] OP_BNE    = 6'h05;
	localparam logic [5:0] OP_BLEZ   = 6'h06;
	localparam logic [5:0] OP_BGTZ   = 6'h07;
	localparam logic [5:0] OP_ADDI   = 6'h08;
	localparam logic [5:0] OP_ADDIU  = 6'h09;
	localparam logic [5:0] OP_SLTI   = 6'h0a;
	localparam logic [5:0] OP_SLTIU  = 6'h0b;
	localparam logic [5:0] OP_ANDI   = 6'h0c;
	localparam logic [5:0] OP_ORI    = 6'h0d;
	localparam logic [5:0] OP_XORI   = 6'h0e;
	localparam logic [5:0] OP_LUI    = 6'h0f;
	localparam logic [5:0] OP_LB     = 6'h20;
	localparam logic [5:0] OP_LH     = 6'h21;
	localparam logic [5:0] OP_LW     = 6'h23;
	localparam logic [5:0] OP_LBU    = 6'h24;
	localparam logic [5:0] OP_LHU    = 6'h25;
	localparam logic [5:0] OP_SB     = 6'h28;
	localparam logic [5:0] OP_SH     = 6'h29;
	localparam logic [5:0] OP_SW     = 6'h2b;

	// function codes of the R-type group, instr[5:0]
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_SLLV = 6'h04;
	localparam logic [5:0] FN_SRLV = 6'h06;
	localparam logic [5:0] FN_SRAV = 6'h07;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// REGIMM branches are told apart by the rt field
	localparam logic [4:0] RT_BLTZ   = 5'h00;
	localparam logic [4:0] RT_BGEZ   = 5'h01;
	localparam logic [4:0] RT_BLTZAL = 5'h10;
	localparam logic [4:0] RT_BGEZAL = 5'h11;

	// OP_RESERVED is encoded as zero so a cleared register reads as no operation
	typedef enum logic [5:0] {
		OP_RESERVED,
		I_SLL, I_SRL, I_SRA, I_SLLV, I_SRLV, I_SRAV,
		I_JR, I_JALR,
		I_ADD, I_ADDU, I_SUB, I_SUBU,
		I_AND, I_OR, I_XOR, I_NOR, I_SLT, I_SLTU,
		I_BLTZ, I_BGEZ, I_BLTZAL, I_BGEZAL,
		I_J, I_JAL, I_BEQ, I_BNE, I_BLEZ, I_BGTZ,
		I_ADDI, I_ADDIU, I_SLTI, I_SLTIU, I_ANDI, I_ORI, I_XORI, I_LUI,
		I_LB, I_LH, I_LW, I_LBU, I_LHU,
		I_SB, I_SH, I_SW
	} instrOp_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} aluFunc_t;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic branch;
		logic jump;
		logic aluSrcImm;
		logic regDst;
		logic link;
		logic zeroExt;
	} ctl_t;

	// ****************************************
	// the three encodings of one 32-bit word
	// ****************************************
	typedef struct packed {
		logic [5:0] op;
		regIdx_t    rs;
		regIdx_t    rt;
		regIdx_t    rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0]  op;
		regIdx_t     rs;
		regIdx_t     rt;
		logic [15:0] imm;
	} iFields_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target;
	} jFields_t;

	typedef union packed {
		rFields_t r;
		iFields_t i;
		jFields_t j;
	} instrWord_t;

endpackage
